// File: cpu_csr.f
+incdir+include
src/csr_pkg.sv
src/csr_access_decode.sv
src/csr_trap_regs.sv
src/csr_instret_counter.sv
src/csr_read_mux.sv
src/csr_top.sv
verif/csr_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the CSR testbench with Verilator, run it, then look for the pass line in the log
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module csr_tb -f cpu_csr.f -o csr_sim > build.log 2>&1 &&
    ./obj_dir/csr_sim > sim.log 2>&1 &&
    grep -q "^TEST PASSED$" sim.log &&
    echo "Simulation passed" ||
    { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// File: src/csr_access_decode.sv
// CSR index decoder with one-hot selects, gated access strobes and illegal-index flag
`timescale 1ns/10ps

module csr_access_decode (
    input  logic              csr_ena,      // Access valid this cycle
    input  logic              csr_wr_en,
    input  logic              csr_rd_en,
    input  csr_pkg::csr_idx_t csr_idx,
    output csr_pkg::csr_sel_t sel,          // One-hot, zero on a miss
    output logic              wr_stb,
    output logic              rd_stb,
    output logic              access_ilgl
);
    import csr_pkg::*;

    ////////////////////
    // Index compare
    ////////////////////
    // Each implemented index owns one select bit
    always_comb begin
        sel[SEL_MSTATUS]   = (csr_idx == IDX_MSTATUS);
        sel[SEL_MISA]      = (csr_idx == IDX_MISA);
        sel[SEL_MIE]       = (csr_idx == IDX_MIE);
        sel[SEL_MTVEC]     = (csr_idx == IDX_MTVEC);
        sel[SEL_MSCRATCH]  = (csr_idx == IDX_MSCRATCH);
        sel[SEL_MEPC]      = (csr_idx == IDX_MEPC);
        sel[SEL_MCAUSE]    = (csr_idx == IDX_MCAUSE);
        sel[SEL_MBADADDR]  = (csr_idx == IDX_MBADADDR);
        sel[SEL_MIP]       = (csr_idx == IDX_MIP);
        sel[SEL_MINSTRET]  = (csr_idx == IDX_MINSTRET);   // Counter low word
        sel[SEL_MINSTRETH] = (csr_idx == IDX_MINSTRETH);  // Counter high word
        sel[SEL_MVENDORID] = (csr_idx == IDX_MVENDORID);
        sel[SEL_MARCHID]   = (csr_idx == IDX_MARCHID);
        sel[SEL_MIMPID]    = (csr_idx == IDX_MIMPID);
        sel[SEL_MHARTID]   = (csr_idx == IDX_MHARTID);
    end

    ////////////////////
    // Strobes
    ////////////////////
    // Write lands at the next edge and read data returns combinationally
    assign wr_stb = csr_ena & csr_wr_en;
    assign rd_stb = csr_ena & csr_rd_en;

    // Enabled access that matched nothing in the table
    assign access_ilgl = csr_ena & ~(|sel);

endmodule

// File: src/csr_instret_counter.sv
// 64-bit retired-instruction counter with separately writable minstret and minstreth
`timescale 1ns/10ps

module csr_instret_counter (
    input  logic              clk,
    input  logic              rst_n,
    input  csr_pkg::csr_sel_t sel,
    input  logic              wr_stb,
    input  csr_pkg::xlen_t    wbck_csr_dat,
    input  logic              cmt_instret_ena,   // One pulse per retired instruction
    output csr_pkg::xlen_t    minstret_r,
    output csr_pkg::xlen_t    minstreth_r
);
    import csr_pkg::*;

    logic wr_lo;
    logic wr_hi;
    logic lo_full;

    assign wr_lo   = wr_stb & sel[SEL_MINSTRET];
    assign wr_hi   = wr_stb & sel[SEL_MINSTRETH];
    assign lo_full = (minstret_r == '1);            // Next increment carries out

    // Low word where a write overrides the count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            minstret_r <= '0;
        end else if (wr_lo) begin
            minstret_r <= wbck_csr_dat;
        end else if (cmt_instret_ena) begin
            minstret_r <= minstret_r + xlen_t'(1);
        end
    end

    // High word takes the carry of the low word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            minstreth_r <= '0;
        end else if (wr_hi) begin
            minstreth_r <= wbck_csr_dat;
        end else if (cmt_instret_ena && lo_full) begin
            minstreth_r <= minstreth_r + xlen_t'(1);
        end
    end

    // Low word seen wrapping from all ones to zero means the high word moved too
    a_instret_carry: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(minstret_r) == '1) && (minstret_r == '0) && !$past(wr_lo) && !$past(wr_hi)
        |-> (minstreth_r != $past(minstreth_r)))
    else $error("csr_instret_counter: low word wrapped without high word carry");

endmodule

// File: src/csr_pkg.sv
// Shared CSR widths, typedefs, index constants, select positions and field bits
package csr_pkg;

    ////////////////////
    // Widths and types
    ////////////////////
    localparam int XLEN    = 32;
    localparam int IDX_W   = 12;
    localparam int CAUSE_W = 4;
    localparam int CSR_NUM = 15;                     // Implemented indices

    typedef logic [XLEN-1:0]    xlen_t;             // One CSR data word
    typedef logic [XLEN-1:0]    pc_t;               // Program counter value
    typedef logic [XLEN-1:0]    addr_t;             // Faulting address
    typedef logic [IDX_W-1:0]   csr_idx_t;          // CSR index from the instruction
    typedef logic [CAUSE_W-1:0] cause_code_t;       // Exception code field of mcause
    typedef logic [CSR_NUM-1:0] csr_sel_t;          // One-hot select, one bit per CSR

    ////////////////////
    // CSR indices
    ////////////////////
    localparam csr_idx_t IDX_MSTATUS   = 12'h300;
    localparam csr_idx_t IDX_MISA      = 12'h301;
    localparam csr_idx_t IDX_MIE       = 12'h304;
    localparam csr_idx_t IDX_MTVEC     = 12'h305;
    localparam csr_idx_t IDX_MSCRATCH  = 12'h340;
    localparam csr_idx_t IDX_MEPC      = 12'h341;
    localparam csr_idx_t IDX_MCAUSE    = 12'h342;
    localparam csr_idx_t IDX_MBADADDR  = 12'h343;
    localparam csr_idx_t IDX_MIP       = 12'h344;
    localparam csr_idx_t IDX_MINSTRET  = 12'hB02;
    localparam csr_idx_t IDX_MINSTRETH = 12'hB82;
    localparam csr_idx_t IDX_MVENDORID = 12'hF11;
    localparam csr_idx_t IDX_MARCHID   = 12'hF12;
    localparam csr_idx_t IDX_MIMPID    = 12'hF13;
    localparam csr_idx_t IDX_MHARTID   = 12'hF14;

    // Bit positions inside csr_sel_t
    localparam int SEL_MSTATUS   = 0;
    localparam int SEL_MISA      = 1;
    localparam int SEL_MIE       = 2;
    localparam int SEL_MTVEC     = 3;
    localparam int SEL_MSCRATCH  = 4;
    localparam int SEL_MEPC      = 5;
    localparam int SEL_MCAUSE    = 6;
    localparam int SEL_MBADADDR  = 7;
    localparam int SEL_MIP       = 8;
    localparam int SEL_MINSTRET  = 9;
    localparam int SEL_MINSTRETH = 10;
    localparam int SEL_MVENDORID = 11;
    localparam int SEL_MARCHID   = 12;
    localparam int SEL_MIMPID    = 13;
    localparam int SEL_MHARTID   = 14;

    ////////////////////
    // Field positions
    ////////////////////
    localparam int STATUS_MIE_BIT  = 3;
    localparam int STATUS_MPIE_BIT = 7;
    localparam int MEIE_BIT = 11;                   // Same slot as MEIP
    localparam int MTIE_BIT = 7;
    localparam int MSIE_BIT = 3;
    localparam int MEIP_BIT = 11;
    localparam int MTIP_BIT = 7;
    localparam int MSIP_BIT = 3;
    localparam int CAUSE_INT_BIT = 31;              // Interrupt flag of mcause

    // MXL=1 (RV32), extensions I, M and C
    localparam xlen_t MISA_VALUE = 32'h4000_1104;

endpackage

// File: src/csr_read_mux.sv
// CSR read path: register and constant images, one-hot select to read data
`timescale 1ns/10ps

module csr_read_mux #(
    parameter csr_pkg::xlen_t TRAP_BASE = 32'h0000_0080,   // Fixed mtvec value
    parameter csr_pkg::xlen_t HART_ID   = 32'h0000_0000
) (
    input  csr_pkg::csr_sel_t sel,
    input  logic              rd_stb,
    input  logic              status_mie_r,
    input  logic              status_mpie_r,
    input  csr_pkg::xlen_t    mie_r,
    input  csr_pkg::xlen_t    mip_r,
    input  csr_pkg::xlen_t    mscratch_r,
    input  csr_pkg::xlen_t    mcause_r,
    input  csr_pkg::pc_t      mepc_r,
    input  csr_pkg::addr_t    mbadaddr_r,
    input  csr_pkg::xlen_t    minstret_r,
    input  csr_pkg::xlen_t    minstreth_r,
    output csr_pkg::xlen_t    read_csr_dat
);
    import csr_pkg::*;

    xlen_t status_img;
    xlen_t img [CSR_NUM];

    ////////////////////
    // mstatus image
    ////////////////////
    // Machine mode only, so MPP reads 11; SD, FS and XS stay zero
    always_comb begin
        status_img                  = '0;
        status_img[12:11]           = 2'b11;
        status_img[STATUS_MPIE_BIT] = status_mpie_r;
        status_img[STATUS_MIE_BIT]  = status_mie_r;
    end

    // Image table, indexed by select position
    always_comb begin
        img[SEL_MSTATUS]   = status_img;
        img[SEL_MISA]      = MISA_VALUE;
        img[SEL_MIE]       = mie_r;
        img[SEL_MTVEC]     = TRAP_BASE;
        img[SEL_MSCRATCH]  = mscratch_r;
        img[SEL_MEPC]      = mepc_r;
        img[SEL_MCAUSE]    = mcause_r;
        img[SEL_MBADADDR]  = mbadaddr_r;
        img[SEL_MIP]       = mip_r;
        img[SEL_MINSTRET]  = minstret_r;
        img[SEL_MINSTRETH] = minstreth_r;
        img[SEL_MVENDORID] = '0;               // Non-commercial core
        img[SEL_MARCHID]   = '0;
        img[SEL_MIMPID]    = '0;
        img[SEL_MHARTID]   = HART_ID;
    end

    ////////////////////
    // AND-OR select
    ////////////////////
    // Zero when no read is enabled or the index missed
    always_comb begin
        read_csr_dat = '0;
        for (int i = 0; i < CSR_NUM; i++) begin
            read_csr_dat = read_csr_dat | ({XLEN{rd_stb & sel[i]}} & img[i]);
        end
    end

endmodule

// File: src/csr_top.sv
// Machine-mode CSR file top level: decode, trap registers, counter and read mux
`timescale 1ns/10ps

module csr_top #(
    parameter csr_pkg::xlen_t TRAP_BASE = 32'h0000_0080,
    parameter csr_pkg::xlen_t HART_ID   = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    // CSR access from the execute and writeback stages
    input  logic               csr_ena,
    input  logic               csr_wr_en,
    input  logic               csr_rd_en,
    input  csr_pkg::csr_idx_t  csr_idx,
    input  csr_pkg::xlen_t     wbck_csr_dat,
    output csr_pkg::xlen_t     read_csr_dat,
    // Interrupt request levels
    input  logic               ext_irq_r,
    input  logic               sft_irq_r,
    input  logic               tmr_irq_r,
    // Commit stage strobes
    input  logic               cmt_status_ena,
    input  logic               cmt_mret_ena,
    input  csr_pkg::pc_t       cmt_epc,
    input  logic               cmt_epc_ena,
    input  csr_pkg::xlen_t     cmt_cause,
    input  logic               cmt_cause_ena,
    input  csr_pkg::addr_t     cmt_badaddr,
    input  logic               cmt_badaddr_ena,
    input  logic               cmt_instret_ena,
    // Interrupt enables and trap addresses to the core
    output logic               status_mie_r,
    output logic               meie_r,
    output logic               mtie_r,
    output logic               msie_r,
    output csr_pkg::pc_t       csr_epc_r,
    output csr_pkg::pc_t       csr_mtvec_r,
    output logic               csr_o_access_ilgl
);
    import csr_pkg::*;

    csr_sel_t sel;
    logic     wr_stb;
    logic     rd_stb;
    logic     status_mpie_r;
    xlen_t    mie_r;
    xlen_t    mip_r;
    xlen_t    mscratch_r;
    xlen_t    mcause_r;
    pc_t      mepc_r;
    addr_t    mbadaddr_r;
    xlen_t    minstret_r;
    xlen_t    minstreth_r;

    csr_access_decode u_decode (
        .csr_ena, .csr_wr_en, .csr_rd_en, .csr_idx,
        .sel, .wr_stb, .rd_stb,
        .access_ilgl (csr_o_access_ilgl)
    );

    csr_trap_regs u_trap (
        .clk, .rst_n, .sel, .wr_stb, .wbck_csr_dat,
        .ext_irq_r, .sft_irq_r, .tmr_irq_r,
        .cmt_status_ena, .cmt_mret_ena,
        .cmt_epc, .cmt_epc_ena, .cmt_cause, .cmt_cause_ena,
        .cmt_badaddr, .cmt_badaddr_ena,
        .status_mie_r, .status_mpie_r, .mie_r, .mip_r,
        .mscratch_r, .mcause_r, .mepc_r, .mbadaddr_r
    );

    csr_instret_counter u_instret (
        .clk, .rst_n, .sel, .wr_stb, .wbck_csr_dat, .cmt_instret_ena,
        .minstret_r, .minstreth_r
    );

    csr_read_mux #(.TRAP_BASE(TRAP_BASE), .HART_ID(HART_ID)) u_rdmux (
        .sel, .rd_stb, .status_mie_r, .status_mpie_r,
        .mie_r, .mip_r, .mscratch_r, .mcause_r, .mepc_r, .mbadaddr_r,
        .minstret_r, .minstreth_r, .read_csr_dat
    );

    // Individual enables for the interrupt arbiter
    assign meie_r = mie_r[MEIE_BIT];
    assign mtie_r = mie_r[MTIE_BIT];
    assign msie_r = mie_r[MSIE_BIT];

    assign csr_epc_r   = mepc_r;        // MRET return target
    assign csr_mtvec_r = TRAP_BASE;     // Trap vector is not writable

endmodule

// File: src/csr_trap_regs.sv
// Trap CSRs mstatus MIE/MPIE, mie, mip sampling, mepc, mcause, mbadaddr and mscratch
`timescale 1ns/10ps

module csr_trap_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  csr_pkg::csr_sel_t   sel,
    input  logic                wr_stb,
    input  csr_pkg::xlen_t      wbck_csr_dat,     // Write data from the writeback stage
    input  logic                ext_irq_r,
    input  logic                sft_irq_r,
    input  logic                tmr_irq_r,
    input  logic                cmt_status_ena,   // Trap taken
    input  logic                cmt_mret_ena,     // MRET committed
    input  csr_pkg::pc_t        cmt_epc,
    input  logic                cmt_epc_ena,
    input  csr_pkg::xlen_t      cmt_cause,
    input  logic                cmt_cause_ena,
    input  csr_pkg::addr_t      cmt_badaddr,
    input  logic                cmt_badaddr_ena,
    output logic                status_mie_r,
    output logic                status_mpie_r,
    output csr_pkg::xlen_t      mie_r,
    output csr_pkg::xlen_t      mip_r,
    output csr_pkg::xlen_t      mscratch_r,
    output csr_pkg::xlen_t      mcause_r,
    output csr_pkg::pc_t        mepc_r,
    output csr_pkg::addr_t      mbadaddr_r
);
    import csr_pkg::*;

    // Only MEIE, MTIE and MSIE are implemented
    localparam xlen_t MIE_MASK = xlen_t'((1 << MEIE_BIT) | (1 << MTIE_BIT) | (1 << MSIE_BIT));

    logic        wr_mstatus;
    logic        wr_mie;
    logic        wr_mscratch;
    logic        wr_mepc;
    logic        wr_mcause;
    logic        wr_mbadaddr;
    logic        meip_q;
    logic        mtip_q;
    logic        msip_q;
    logic        cause_int_q;
    cause_code_t cause_code_q;

    // Per-register write enables
    assign wr_mstatus  = wr_stb & sel[SEL_MSTATUS];
    assign wr_mie      = wr_stb & sel[SEL_MIE];
    assign wr_mscratch = wr_stb & sel[SEL_MSCRATCH];
    assign wr_mepc     = wr_stb & sel[SEL_MEPC];
    assign wr_mcause   = wr_stb & sel[SEL_MCAUSE];
    assign wr_mbadaddr = wr_stb & sel[SEL_MBADADDR];

    ////////////////////
    // mstatus fields
    ////////////////////
    // Trap entry beats MRET, MRET beats a CSR write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_mie_r  <= 1'b0;
            status_mpie_r <= 1'b0;
        end else if (cmt_status_ena) begin
            status_mpie_r <= status_mie_r;        // Save current enable
            status_mie_r  <= 1'b0;                // Handler runs with interrupts off
        end else if (cmt_mret_ena) begin
            status_mie_r  <= status_mpie_r;       // Restore
            status_mpie_r <= 1'b1;
        end else if (wr_mstatus) begin
            status_mie_r  <= wbck_csr_dat[STATUS_MIE_BIT];
            status_mpie_r <= wbck_csr_dat[STATUS_MPIE_BIT];
        end
    end

    ////////////////////
    // mie and mip
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_r <= '0;
        end else if (wr_mie) begin
            mie_r <= wbck_csr_dat & MIE_MASK;
        end
    end

    // Pending bits are the request levels one cycle late and writes are ignored
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meip_q <= 1'b0;
            mtip_q <= 1'b0;
            msip_q <= 1'b0;
        end else begin
            meip_q <= ext_irq_r;
            mtip_q <= tmr_irq_r;
            msip_q <= sft_irq_r;
        end
    end

    always_comb begin
        mip_r           = '0;
        mip_r[MEIP_BIT] = meip_q;
        mip_r[MTIP_BIT] = mtip_q;
        mip_r[MSIP_BIT] = msip_q;
    end

    ////////////////////
    // Trap data regs
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch_r <= '0;
        end else if (wr_mscratch) begin
            mscratch_r <= wbck_csr_dat;
        end
    end

    // Commit strobes beat software writes; mepc is kept halfword aligned
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc_r <= '0;
        end else if (cmt_epc_ena) begin
            mepc_r <= {cmt_epc[XLEN-1:1], 1'b0};
        end else if (wr_mepc) begin
            mepc_r <= {wbck_csr_dat[XLEN-1:1], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cause_int_q  <= 1'b0;
            cause_code_q <= '0;
        end else if (cmt_cause_ena) begin
            cause_int_q  <= cmt_cause[CAUSE_INT_BIT];
            cause_code_q <= cmt_cause[CAUSE_W-1:0];
        end else if (wr_mcause) begin
            cause_int_q  <= wbck_csr_dat[CAUSE_INT_BIT];
            cause_code_q <= wbck_csr_dat[CAUSE_W-1:0];      // Up to 16 causes
        end
    end

    assign mcause_r = {cause_int_q, {(XLEN-1-CAUSE_W){1'b0}}, cause_code_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mbadaddr_r <= '0;
        end else if (cmt_badaddr_ena) begin
            mbadaddr_r <= cmt_badaddr;
        end else if (wr_mbadaddr) begin
            mbadaddr_r <= wbck_csr_dat;
        end
    end

    // Commit stage retires either a trap or an MRET, never both at once
    a_trap_mret_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(cmt_status_ena && cmt_mret_ena))
    else $error("csr_trap_regs: trap entry and MRET in the same cycle");

endmodule

// File: include/csr_tb_model.svh
// Reference model of the CSR file with shadow registers, read prediction, write and trap rules
`ifndef CSR_TB_MODEL_SVH
`define CSR_TB_MODEL_SVH

////////////////////
// Shadow state
////////////////////
logic [31:0] m_mie;             // Enable bits 11, 7, 3 only
logic [31:0] m_mscratch;
logic [31:0] m_mepc;
logic [31:0] m_mcause;
logic [31:0] m_mbadaddr;
logic        m_st_mie;          // mstatus.MIE
logic        m_st_mpie;         // mstatus.MPIE
logic [2:0]  m_irq;             // {ext, tmr, sft} as mip shows them
logic [63:0] m_instret;

function automatic logic is_implemented(input logic [11:0] idx);
    case (idx)
        12'h300, 12'h301, 12'h304, 12'h305, 12'h340, 12'h341, 12'h342, 12'h343,
        12'h344, 12'hB02, 12'hB82, 12'hF11, 12'hF12, 12'hF13, 12'hF14: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// Expected read data for an enabled read
function automatic logic [31:0] predict_read(input logic [11:0] idx);
    case (idx)
        12'h300: return {19'b0, 2'b11, 3'b0, m_st_mpie, 3'b0, m_st_mie, 3'b0};  // MPP = 11
        12'h301: return 32'h4000_1104;
        12'h304: return m_mie;
        12'h305: return TRAP_BASE;
        12'h340: return m_mscratch;
        12'h341: return m_mepc;
        12'h342: return m_mcause;
        12'h343: return m_mbadaddr;
        12'h344: return {20'b0, m_irq[2], 3'b0, m_irq[1], 3'b0, m_irq[0], 3'b0};
        12'hB02: return m_instret[31:0];
        12'hB82: return m_instret[63:32];
        12'hF14: return HART_ID;
        default: return 32'h0;          // IDs and unimplemented indices
    endcase
endfunction

// Also used for commit values, which follow the same field masks
task automatic apply_write(input logic [11:0] idx, input logic [31:0] dat);
    case (idx)
        12'h300: begin
            m_st_mie  = dat[3];
            m_st_mpie = dat[7];
        end
        12'h304: m_mie      = dat & 32'h0000_0888;
        12'h340: m_mscratch = dat;
        12'h341: m_mepc     = {dat[31:1], 1'b0};    // Halfword aligned
        12'h342: m_mcause   = dat & 32'h8000_000F;
        12'h343: m_mbadaddr = dat;
        12'hB02: m_instret[31:0]  = dat;
        12'hB82: m_instret[63:32] = dat;
        default: ;                                  // Read-only or unimplemented
    endcase
endtask

task automatic enter_trap();
    m_st_mpie = m_st_mie;
    m_st_mie  = 1'b0;
endtask

task automatic leave_trap();
    m_st_mie  = m_st_mpie;
    m_st_mpie = 1'b1;
endtask

task automatic reset_shadow();
    m_mie      = '0;
    m_mscratch = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_mbadaddr = '0;
    m_st_mie   = 1'b0;
    m_st_mpie  = 1'b0;
    m_irq      = '0;
    m_instret  = '0;
endtask

`endif

// File: verif/csr_tb.sv
// CSR file testbench with clock, reset, random stimulus, model comparison and reporting
`timescale 1ns/10ps

module csr_tb;
    localparam logic [31:0] TRAP_BASE = 32'h0000_0080;
    localparam logic [31:0] HART_ID   = 32'h0000_0000;
    localparam int CLK_HALF   = 20;               // 40 ns period
    localparam int MAX_CYCLES = 2000;             // Watchdog limit

    logic        clk;
    logic        rst_n;
    logic        csr_ena, csr_wr_en, csr_rd_en;
    logic [11:0] csr_idx;
    logic [31:0] wbck_csr_dat, read_csr_dat;
    logic        ext_irq_r, sft_irq_r, tmr_irq_r;
    logic        cmt_status_ena, cmt_mret_ena, cmt_instret_ena;
    logic [31:0] cmt_epc, cmt_cause, cmt_badaddr;
    logic        cmt_epc_ena, cmt_cause_ena, cmt_badaddr_ena;
    logic        status_mie_r, meie_r, mtie_r, msie_r, csr_o_access_ilgl;
    logic [31:0] csr_epc_r, csr_mtvec_r;

    integer      seed = 17483;
    integer      pass_cnt;
    integer      fail_cnt;
    integer      test_base;                       // fail_cnt when the test started
    logic [11:0] wr_idx [6];                      // Writable indices
    logic [11:0] ro_idx [6];                      // Read-only indices

    `include "csr_tb_model.svh"

    csr_top #(.TRAP_BASE(TRAP_BASE), .HART_ID(HART_ID)) dut0 (.*);

    always #(CLK_HALF) clk = ~clk;

    ////////////////////
    // Helpers
    ////////////////////
    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic end_test(input string name);
        $display("%-36s %0d failed checks", name, fail_cnt - test_base);
        test_base = fail_cnt;
    endtask

    task automatic clear_strobes();
        csr_ena         = 1'b0;
        csr_wr_en       = 1'b0;
        csr_rd_en       = 1'b0;
        cmt_status_ena  = 1'b0;
        cmt_mret_ena    = 1'b0;
        cmt_epc_ena     = 1'b0;
        cmt_cause_ena   = 1'b0;
        cmt_badaddr_ena = 1'b0;
        cmt_instret_ena = 1'b0;
    endtask

    // Enables and trap addresses seen by the core
    task automatic check_outputs();
        check_val("status_mie_r", {31'b0, status_mie_r}, {31'b0, m_st_mie});
        check_val("meie_r", {31'b0, meie_r}, {31'b0, m_mie[11]});
        check_val("mtie_r", {31'b0, mtie_r}, {31'b0, m_mie[7]});
        check_val("msie_r", {31'b0, msie_r}, {31'b0, m_mie[3]});
        check_val("csr_epc_r", csr_epc_r, m_mepc);
        check_val("csr_mtvec_r", csr_mtvec_r, TRAP_BASE);
    endtask

    ////////////////////
    // Bus operations
    ////////////////////
    task automatic csr_write(input logic [11:0] idx, input logic [31:0] dat, input logic ena);
        @(negedge clk);
        clear_strobes();
        csr_ena      = ena;
        csr_wr_en    = 1'b1;
        csr_idx      = idx;
        wbck_csr_dat = dat;
        if (ena) begin
            apply_write(idx, dat);                // Lands at the next rising edge
        end else begin
            #5;
            check_val("csr_o_access_ilgl", {31'b0, csr_o_access_ilgl}, 32'h0);
        end
    endtask

    // Read data is combinational and sampled mid-cycle
    task automatic csr_read_check(input logic [11:0] idx);
        @(negedge clk);
        clear_strobes();
        csr_ena   = 1'b1;
        csr_rd_en = 1'b1;
        csr_idx   = idx;
        #5;
        check_val($sformatf("read_csr_dat[%h]", idx), read_csr_dat, predict_read(idx));
        check_val("csr_o_access_ilgl", {31'b0, csr_o_access_ilgl},
                  {31'b0, !is_implemented(idx)});
        check_outputs();
    endtask

    // Write and commit strobe on the same register in one cycle
    task automatic commit_over_write(input logic [11:0] idx, input logic [31:0] wdat,
                                     input logic [31:0] cdat);
        @(negedge clk);
        clear_strobes();
        csr_ena      = 1'b1;
        csr_wr_en    = 1'b1;
        csr_idx      = idx;
        wbck_csr_dat = wdat;
        case (idx)
            12'h341: begin
                cmt_epc     = cdat;
                cmt_epc_ena = 1'b1;
            end
            12'h342: begin
                cmt_cause     = cdat;
                cmt_cause_ena = 1'b1;
            end
            default: begin
                cmt_badaddr     = cdat;
                cmt_badaddr_ena = 1'b1;
            end
        endcase
        apply_write(idx, cdat);                   // Commit value wins
    endtask

    // Trap entry or MRET against a competing mstatus write
    task automatic trap_event(input logic is_mret, input logic [31:0] wdat);
        @(negedge clk);
        clear_strobes();
        csr_ena      = 1'b1;
        csr_wr_en    = 1'b1;
        csr_idx      = 12'h300;
        wbck_csr_dat = wdat;
        if (is_mret) begin
            cmt_mret_ena = 1'b1;
            leave_trap();
        end else begin
            cmt_status_ena = 1'b1;
            enter_trap();
        end
    endtask

    // New levels must not show in mip before the next edge
    task automatic set_irq(input logic [2:0] lv);
        @(negedge clk);
        clear_strobes();
        ext_irq_r = lv[2];
        tmr_irq_r = lv[1];
        sft_irq_r = lv[0];
        csr_ena   = 1'b1;
        csr_rd_en = 1'b1;
        csr_idx   = 12'h344;
        #5;
        check_val("read_csr_dat[344]", read_csr_dat, predict_read(12'h344));
        m_irq     = lv;                           // Visible after the next edge
    endtask

    task automatic instret_pulse(input logic en);
        @(negedge clk);
        clear_strobes();
        cmt_instret_ena = en;
        if (en) m_instret = m_instret + 64'd1;
    endtask

    ////////////////////
    // Watchdog
    ////////////////////
    initial begin
        #(2 * CLK_HALF * MAX_CYCLES);
        abort_run("Timeout: simulation ran past its cycle limit");
    end

    ////////////////////
    // Test sequence
    ////////////////////
    initial begin
        integer      i;
        integer      k;
        logic [31:0] r;
        clk       = 1'b0;
        rst_n     = 1'b0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        test_base = 0;
        wr_idx = '{12'h340, 12'h304, 12'h341, 12'h342, 12'h343, 12'h300};
        ro_idx = '{12'h301, 12'h305, 12'hF11, 12'hF12, 12'hF13, 12'hF14};
        clear_strobes();
        csr_idx      = '0;
        wbck_csr_dat = '0;
        {ext_irq_r, tmr_irq_r, sft_irq_r} = 3'b000;
        {cmt_epc, cmt_cause, cmt_badaddr} = '0;
        reset_shadow();

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #5;
        // All registers start at zero and no access is pending
        check_val("csr_o_access_ilgl", {31'b0, csr_o_access_ilgl}, 32'h0);
        check_outputs();

        for (i = 0; i < 40; i++) begin
            r = rand32();
            k = int'(r[7:0] % 8'd6);
            csr_write(wr_idx[k], rand32(), r[9:8] != 2'b00);  // About a quarter disabled
            csr_read_check(wr_idx[k]);
        end
        end_test("1 read/write with field masks");

        for (i = 0; i < 12; i++) begin
            csr_write(ro_idx[i % 6], rand32(), 1'b1);
            csr_read_check(ro_idx[i % 6]);
        end
        end_test("2 read-only constants");

        csr_write(12'h300, 32'h0000_0008, 1'b1);      // MIE on, MPIE off
        csr_read_check(12'h300);
        for (i = 0; i < 5; i++) begin
            trap_event(1'b0, rand32());
            csr_read_check(12'h300);
            trap_event(1'b1, rand32());
            csr_read_check(12'h300);
            commit_over_write(12'h341 + 12'(i % 3), rand32(), rand32());
            csr_read_check(12'h341 + 12'(i % 3));
            csr_write(12'h300, rand32(), 1'b1);
        end
        end_test("3 trap entry, MRET and commit");

        for (i = 0; i < 10; i++) begin
            r = rand32();
            set_irq(r[2:0]);
            csr_read_check(12'h344);
            csr_write(12'h304, rand32(), 1'b1);
            csr_read_check(12'h304);              // Also checks meie/mtie/msie
        end
        end_test("4 irq sampling and enables");

        for (i = 0; i < 24; i++) begin
            r = rand32();
            instret_pulse(r[0]);
        end
        csr_read_check(12'hB02);
        csr_read_check(12'hB82);
        csr_write(12'hB02, 32'hFFFF_FFFF, 1'b1);
        csr_write(12'hB82, rand32(), 1'b1);
        instret_pulse(1'b1);                      // Low word wraps and high word carries
        csr_read_check(12'hB02);
        csr_read_check(12'hB82);
        end_test("5 retired-instruction counter");

        for (i = 0; i < 12; i++) begin
            r = rand32();
            while (is_implemented(r[11:0])) r = rand32();
            csr_write(r[11:0], rand32(), 1'b1);   // Must change nothing
            csr_read_check(r[11:0]);
            csr_read_check(wr_idx[i % 6]);
        end
        end_test("6 unimplemented index flag");

        $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
